//--- ctl_pkg.sv
package ctl_pkg;

  // ==================================================
  // Sizes
  // ==================================================

  localparam int num_trans = 8;
  localparam int trans_idx_w = $clog2(num_trans);

  localparam int bank_depth = 128;
  localparam int bank_addr_w = $clog2(bank_depth);

  // Host page select.
  localparam logic [2:0] page_main = 3'd0;
  localparam logic [2:0] page_delay = 3'd2;

  // ==================================================
  // Register map of the main page
  // ==================================================

  localparam logic [bank_addr_w-1:0] addr_ctl_flag = 7'h00;
  localparam logic [bank_addr_w-1:0] addr_fpga_info = 7'h01;
  localparam logic [bank_addr_w-1:0] addr_sync_time_0 = 7'h11;
  localparam logic [bank_addr_w-1:0] addr_sync_time_1 = 7'h12;
  localparam logic [bank_addr_w-1:0] addr_sync_time_2 = 7'h13;
  localparam logic [bank_addr_w-1:0] addr_sync_time_3 = 7'h14;
  localparam logic [bank_addr_w-1:0] addr_mod_cycle = 7'h20;
  localparam logic [bank_addr_w-1:0] addr_mod_freq_div_0 = 7'h21;
  localparam logic [bank_addr_w-1:0] addr_mod_freq_div_1 = 7'h22;
  localparam logic [bank_addr_w-1:0] addr_silent_step = 7'h28;
  localparam logic [bank_addr_w-1:0] addr_ver_minor = 7'h3e;
  localparam logic [bank_addr_w-1:0] addr_ver_major = 7'h3f;
  localparam logic [bank_addr_w-1:0] addr_stm_cycle = 7'h50;
  localparam logic [bank_addr_w-1:0] addr_stm_freq_div_0 = 7'h51;
  localparam logic [bank_addr_w-1:0] addr_stm_freq_div_1 = 7'h52;
  localparam logic [bank_addr_w-1:0] addr_sound_speed_0 = 7'h53;
  localparam logic [bank_addr_w-1:0] addr_sound_speed_1 = 7'h54;
  localparam logic [bank_addr_w-1:0] addr_stm_start_idx = 7'h55;
  localparam logic [bank_addr_w-1:0] addr_stm_finish_idx = 7'h56;

  localparam logic [7:0] version_major = 8'h0d;
  localparam logic [7:0] version_minor = 8'h01;

  // Flag word bit positions.
  localparam int flag_op_mode_bit = 9;
  localparam int flag_stm_gain_mode_bit = 10;
  localparam int flag_use_stm_start_idx_bit = 11;
  localparam int flag_use_stm_finish_idx_bit = 12;
  localparam int flag_force_fan_bit = 13;
  localparam int flag_sync_bit = 15;

  // ==================================================
  // Types
  // ==================================================

  typedef struct packed {
    logic        en;
    logic        we;
    logic [2:0]  page;
    logic [7:0]  addr;
    logic [15:0] wdata;
  } host_bus_t;

  // Field order follows the bit positions above, msb first.
  typedef struct packed {
    logic       sync;
    logic       rsv_14;
    logic       force_fan;
    logic       use_stm_finish_idx;
    logic       use_stm_start_idx;
    logic       stm_gain_mode;
    logic       op_mode;
    logic [8:0] rsv_lo;
  } ctl_flags_t;

  typedef union packed {
    logic [15:0] raw;
    ctl_flags_t  flags;
  } ctl_word_u;

  typedef struct packed {
    logic [15:0] cycle;
    logic [31:0] freq_div;
    logic [8:0]  step;
  } mod_cfg_t;

  typedef struct packed {
    logic [15:0] cycle;
    logic [31:0] freq_div;
    logic [31:0] sound_speed;
    logic [15:0] start_idx;
    logic [15:0] finish_idx;
  } stm_cfg_t;

  typedef logic [num_trans-1:0][15:0] delay_arr_t;

endpackage

//--- ctl_regbank.sv
`timescale 1ns/1ps

module ctl_regbank
  import ctl_pkg::*;
(
  input  logic                   CLK,
  input  host_bus_t              host,
  output logic [15:0]            rdata,
  input  logic [bank_addr_w-1:0] b_addr,
  input  logic                   b_we,
  input  logic [15:0]            b_wdata,
  output logic [15:0]            b_rdata
);

  logic [15:0] mem [bank_depth];
  logic [bank_addr_w-1:0] host_addr;
  logic [bank_addr_w-1:0] b_addr_q;

  assign host_addr = host.addr[bank_addr_w-1:0];

  // ==================================================
  // Write ports
  // ==================================================

  always_ff @(posedge CLK) begin
    if (host.en && host.we) begin
      mem[host_addr] <= host.wdata;
    end
    // Port B comes last so it wins a same-address collision.
    if (b_we) begin
      mem[b_addr] <= b_wdata;
    end
  end

  // ==================================================
  // Read ports
  // ==================================================

  // Host side, read first, zero when not selected.
  always_ff @(posedge CLK) begin
    if (host.en) begin
      rdata <= mem[host_addr];
    end else begin
      rdata <= '0;
    end
  end

  // Registered address and registered output.
  always_ff @(posedge CLK) begin
    b_addr_q <= b_addr;
    b_rdata <= mem[b_addr_q];
  end

endmodule

//--- delay_table.sv
`timescale 1ns/1ps

module delay_table
  import ctl_pkg::*;
(
  input  logic       CLK,
  input  logic       arst_n,
  input  host_bus_t  host,
  output delay_arr_t delays
);

  logic [15:0] ram [num_trans];

  logic [trans_idx_w-1:0] rd_cnt;
  logic [trans_idx_w-1:0] wr_idx;
  logic [15:0] rd_q;
  logic [15:0] rd_qq;

  function automatic logic [trans_idx_w-1:0] wrap_inc(input logic [trans_idx_w-1:0] v);
    if (v == trans_idx_w'(num_trans - 1)) begin
      return '0;
    end
    return v + 1'b1;
  endfunction

  // ==================================================
  // Host write port
  // ==================================================

  always_ff @(posedge CLK) begin
    if (host.en && host.we) begin
      ram[host.addr[trans_idx_w-1:0]] <= host.wdata;
    end
  end

  // ==================================================
  // Unloader
  // ==================================================

  // Two-stage read, like a block RAM with output register.
  always_ff @(posedge CLK) begin
    rd_q <= ram[rd_cnt];
    rd_qq <= rd_q;
  end

  // Write index trails the read counter by the pipeline depth.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      rd_cnt <= '0;
      wr_idx <= trans_idx_w'(num_trans - 2);
      delays <= '0;
    end else begin
      rd_cnt <= wrap_inc(rd_cnt);
      wr_idx <= wrap_inc(wr_idx);
      delays[wr_idx] <= rd_qq;
    end
  end

endmodule

//--- ctl_sequencer.sv
`timescale 1ns/1ps

module ctl_sequencer
  import ctl_pkg::*;
(
  input  logic                   CLK,
  input  logic                   arst_n,
  input  logic                   thermo,
  output logic [bank_addr_w-1:0] b_addr,
  output logic                   b_we,
  output logic [15:0]            b_wdata,
  input  logic [15:0]            b_rdata,
  output ctl_flags_t             flags,
  output mod_cfg_t               mod_cfg,
  output stm_cfg_t               stm_cfg,
  output logic [63:0]            ecat_sync_time,
  output logic                   sync_set
);

  // Names read <store>_<request>; data lands three states after its request.
  typedef enum logic [4:0] {
    s_wr_ver_minor,
    s_wr_ver_major,
    s_req_flag,
    s_st_finish_req_flag,
    s_req_mod_cycle,
    s_req_mod_div_0,
    s_st_flag_req_mod_div_1,
    s_st_mod_cycle_req_step,
    s_st_mod_div_0_req_stm_cycle,
    s_st_mod_div_1_req_stm_div_0,
    s_st_step_req_stm_div_1,
    s_st_stm_cycle_req_speed_0,
    s_st_stm_div_0_req_speed_1,
    s_st_stm_div_1_req_start,
    s_st_speed_0_req_finish,
    s_st_speed_1_wr_info,
    s_st_start_idle,
    s_sync_req_0,
    s_sync_req_1,
    s_sync_req_2,
    s_sync_st_0_req_3,
    s_sync_st_1,
    s_sync_st_2,
    s_sync_st_3
  } state_t;

  state_t state;
  ctl_word_u rd_word;
  ctl_word_u clr_word;

  // Flag word as read, and the same word with sync dropped.
  always_comb begin
    rd_word.raw = b_rdata;
    clr_word.raw = b_rdata;
    clr_word.raw[flag_sync_bit] = 1'b0;
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state <= s_wr_ver_minor;
      b_addr <= '0;
      b_we <= 1'b0;
      b_wdata <= '0;
      flags <= '0;
      mod_cfg <= '0;
      stm_cfg <= '0;
      ecat_sync_time <= '0;
      sync_set <= 1'b0;
    end else begin
      b_we <= 1'b0;
      sync_set <= 1'b0;
      case (state)
        // ==================================================
        // Init
        // ==================================================
        s_wr_ver_minor: begin
          b_we <= 1'b1;
          b_addr <= addr_ver_minor;
          b_wdata <= {8'h00, version_minor};
          state <= s_wr_ver_major;
        end
        s_wr_ver_major: begin
          b_we <= 1'b1;
          b_addr <= addr_ver_major;
          b_wdata <= {8'hff, version_major};
          state <= s_req_flag;
        end
        s_req_flag: begin
          b_addr <= addr_ctl_flag;
          state <= s_req_mod_cycle;
        end
        // ==================================================
        // Run, 14 states per loop
        // ==================================================
        s_st_finish_req_flag: begin
          stm_cfg.finish_idx <= b_rdata;
          b_addr <= addr_ctl_flag;
          state <= s_req_mod_cycle;
        end
        s_req_mod_cycle: begin
          b_addr <= addr_mod_cycle;
          state <= s_req_mod_div_0;
        end
        s_req_mod_div_0: begin
          b_addr <= addr_mod_freq_div_0;
          state <= s_st_flag_req_mod_div_1;
        end
        s_st_flag_req_mod_div_1: begin
          flags <= clr_word.flags;
          if (rd_word.flags.sync) begin
            b_we <= 1'b1;
            b_addr <= addr_ctl_flag;
            b_wdata <= clr_word.raw;
            state <= s_sync_req_0;
          end else begin
            b_addr <= addr_mod_freq_div_1;
            state <= s_st_mod_cycle_req_step;
          end
        end
        s_st_mod_cycle_req_step: begin
          mod_cfg.cycle <= b_rdata;
          b_addr <= addr_silent_step;
          state <= s_st_mod_div_0_req_stm_cycle;
        end
        s_st_mod_div_0_req_stm_cycle: begin
          mod_cfg.freq_div[15:0] <= b_rdata;
          b_addr <= addr_stm_cycle;
          state <= s_st_mod_div_1_req_stm_div_0;
        end
        s_st_mod_div_1_req_stm_div_0: begin
          mod_cfg.freq_div[31:16] <= b_rdata;
          b_addr <= addr_stm_freq_div_0;
          state <= s_st_step_req_stm_div_1;
        end
        s_st_step_req_stm_div_1: begin
          mod_cfg.step <= b_rdata[8:0];
          b_addr <= addr_stm_freq_div_1;
          state <= s_st_stm_cycle_req_speed_0;
        end
        s_st_stm_cycle_req_speed_0: begin
          stm_cfg.cycle <= b_rdata;
          b_addr <= addr_sound_speed_0;
          state <= s_st_stm_div_0_req_speed_1;
        end
        s_st_stm_div_0_req_speed_1: begin
          stm_cfg.freq_div[15:0] <= b_rdata;
          b_addr <= addr_sound_speed_1;
          state <= s_st_stm_div_1_req_start;
        end
        s_st_stm_div_1_req_start: begin
          stm_cfg.freq_div[31:16] <= b_rdata;
          b_addr <= addr_stm_start_idx;
          state <= s_st_speed_0_req_finish;
        end
        s_st_speed_0_req_finish: begin
          stm_cfg.sound_speed[15:0] <= b_rdata;
          b_addr <= addr_stm_finish_idx;
          state <= s_st_speed_1_wr_info;
        end
        s_st_speed_1_wr_info: begin
          stm_cfg.sound_speed[31:16] <= b_rdata;
          b_we <= 1'b1;
          b_addr <= addr_fpga_info;
          b_wdata <= {15'd0, thermo};
          state <= s_st_start_idle;
        end
        s_st_start_idle: begin
          stm_cfg.start_idx <= b_rdata;
          state <= s_st_finish_req_flag;
        end
        // ==================================================
        // Synchronize
        // ==================================================
        s_sync_req_0: begin
          b_addr <= addr_sync_time_0;
          state <= s_sync_req_1;
        end
        s_sync_req_1: begin
          b_addr <= addr_sync_time_1;
          state <= s_sync_req_2;
        end
        s_sync_req_2: begin
          b_addr <= addr_sync_time_2;
          state <= s_sync_st_0_req_3;
        end
        s_sync_st_0_req_3: begin
          ecat_sync_time[15:0] <= b_rdata;
          b_addr <= addr_sync_time_3;
          state <= s_sync_st_1;
        end
        s_sync_st_1: begin
          ecat_sync_time[31:16] <= b_rdata;
          state <= s_sync_st_2;
        end
        s_sync_st_2: begin
          ecat_sync_time[47:32] <= b_rdata;
          state <= s_sync_st_3;
        end
        s_sync_st_3: begin
          ecat_sync_time[63:48] <= b_rdata;
          sync_set <= 1'b1;
          // Flag request here rejoins the loop in step.
          b_addr <= addr_ctl_flag;
          state <= s_req_mod_cycle;
        end
        default: begin
          state <= s_wr_ver_minor;
        end
      endcase
    end
  end

endmodule

//--- ctl_top.sv
`timescale 1ns/1ps

module ctl_top
  import ctl_pkg::*;
(
  input  logic        CLK,
  input  logic        arst_n,
  input  logic        thermo,
  input  host_bus_t   host,
  output logic [15:0] rdata,
  output logic        force_fan,
  output ctl_flags_t  flags,
  output mod_cfg_t    mod_cfg,
  output stm_cfg_t    stm_cfg,
  output logic [63:0] ecat_sync_time,
  output logic        sync_set,
  output delay_arr_t  delays
);

  host_bus_t bank_host;
  host_bus_t dly_host;

  logic [bank_addr_w-1:0] b_addr;
  logic b_we;
  logic [15:0] b_wdata;
  logic [15:0] b_rdata;

  // Page decode.
  always_comb begin
    bank_host = host;
    bank_host.en = host.en && (host.page == page_main);
    dly_host = host;
    dly_host.en = host.en && (host.page == page_delay);
  end

  assign force_fan = flags.force_fan;

  ctl_regbank ctl_regbank_i (
    .CLK     (CLK),
    .host    (bank_host),
    .rdata   (rdata),
    .b_addr  (b_addr),
    .b_we    (b_we),
    .b_wdata (b_wdata),
    .b_rdata (b_rdata)
  );

  delay_table delay_table_i (
    .CLK    (CLK),
    .arst_n (arst_n),
    .host   (dly_host),
    .delays (delays)
  );

  ctl_sequencer ctl_sequencer_i (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .thermo         (thermo),
    .b_addr         (b_addr),
    .b_we           (b_we),
    .b_wdata        (b_wdata),
    .b_rdata        (b_rdata),
    .flags          (flags),
    .mod_cfg        (mod_cfg),
    .stm_cfg        (stm_cfg),
    .ecat_sync_time (ecat_sync_time),
    .sync_set       (sync_set)
  );

endmodule

//--- ctl_chk.sv
`timescale 1ns/1ps

module ctl_chk
  import ctl_pkg::*;
(
  input logic                   CLK,
  input logic                   arst_n,
  input logic                   seq_on,
  input logic                   tbl_on,
  input logic                   sync_set,
  input logic                   b_we,
  input logic [bank_addr_w-1:0] b_addr,
  input logic [trans_idx_w-1:0] rd_cnt,
  input logic [trans_idx_w-1:0] wr_idx
);

  // ==================================================
  // Sequencer
  // ==================================================

  sync_pulse_a: assert property (@(posedge CLK) disable iff (!arst_n || !seq_on)
    sync_set |=> !sync_set)
    else $error("sync_set high on two consecutive cycles");

  // Only the version writes come back to back.
  bank_we_a: assert property (@(posedge CLK) disable iff (!arst_n || !seq_on)
    (b_we && $past(b_we)) |-> (b_addr == addr_ver_major))
    else $error("port B written on two consecutive poll cycles");

  // ==================================================
  // Delay table
  // ==================================================

  // Read counter advances every cycle and wraps at the table depth.
  cnt_step_a: assert property (@(posedge CLK) disable iff (!arst_n || !tbl_on)
    $past(arst_n) |-> int'(rd_cnt) == (int'($past(rd_cnt)) + 1) % num_trans)
    else $error("delay table read counter did not step and wrap");

  // Write index trails by the read pipeline depth.
  trail_a: assert property (@(posedge CLK) disable iff (!arst_n || !tbl_on)
    int'(wr_idx) == (int'(rd_cnt) + num_trans - 2) % num_trans)
    else $error("delay table write index lost step with read counter");

endmodule

bind ctl_sequencer ctl_chk seq_chk_i (
  .CLK      (CLK),
  .arst_n   (arst_n),
  .seq_on   (1'b1),
  .tbl_on   (1'b0),
  .sync_set (sync_set),
  .b_we     (b_we),
  .b_addr   (b_addr),
  .rd_cnt   ('0),
  .wr_idx   ('0)
);

bind delay_table ctl_chk tbl_chk_i (
  .CLK      (CLK),
  .arst_n   (arst_n),
  .seq_on   (1'b0),
  .tbl_on   (1'b1),
  .sync_set (1'b0),
  .b_we     (1'b0),
  .b_addr   ('0),
  .rd_cnt   (rd_cnt),
  .wr_idx   (wr_idx)
);

//--- ctl_tb.sv
`timescale 1ns/1ps

module ctl_tb
  import ctl_pkg::*;
();

  localparam int setting_rounds = 4;
  localparam int thermo_rounds = 4;
  localparam int sync_rounds = 3;
  localparam int delay_writes = 16;
  localparam int setting_wait = 28;
  localparam int sync_wait = 40;
  localparam int delay_wait = num_trans + 2;
  localparam int num_ops = 2 + 2 * setting_rounds + thermo_rounds + 3 * sync_rounds
                           + num_trans + delay_writes + 2;
  localparam int cycle_limit = 40 * num_ops + 200;

  localparam logic [bank_addr_w-1:0] setting_addrs [11] = '{
    addr_mod_cycle, addr_mod_freq_div_0, addr_mod_freq_div_1, addr_silent_step,
    addr_stm_cycle, addr_stm_freq_div_0, addr_stm_freq_div_1, addr_sound_speed_0,
    addr_sound_speed_1, addr_stm_start_idx, addr_stm_finish_idx
  };

  logic CLK;
  logic arst_n;
  logic thermo;
  host_bus_t host;
  logic [15:0] rdata;
  logic force_fan;
  ctl_flags_t flags;
  mod_cfg_t mod_cfg;
  stm_cfg_t stm_cfg;
  logic [63:0] ecat_sync_time;
  logic sync_set;
  delay_arr_t delays;

  logic [15:0] bank_model [bank_depth];
  logic [15:0] delay_model [num_trans];
  logic [15:0] lfsr_state;
  int mismatch_cnt;
  int fail_cnt;
  int cycle_cnt;

  ctl_top ctl_top_i (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .thermo         (thermo),
    .host           (host),
    .rdata          (rdata),
    .force_fan      (force_fan),
    .flags          (flags),
    .mod_cfg        (mod_cfg),
    .stm_cfg        (stm_cfg),
    .ecat_sync_time (ecat_sync_time),
    .sync_set       (sync_set),
    .delays         (delays)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // ==================================================
  // Helpers
  // ==================================================

  // x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic mod_cfg_t expect_mod();
    mod_cfg_t m;
    m.cycle = bank_model[addr_mod_cycle];
    m.freq_div = {bank_model[addr_mod_freq_div_1], bank_model[addr_mod_freq_div_0]};
    m.step = bank_model[addr_silent_step][8:0];
    return m;
  endfunction

  function automatic stm_cfg_t expect_stm();
    stm_cfg_t s;
    s.cycle = bank_model[addr_stm_cycle];
    s.freq_div = {bank_model[addr_stm_freq_div_1], bank_model[addr_stm_freq_div_0]};
    s.sound_speed = {bank_model[addr_sound_speed_1], bank_model[addr_sound_speed_0]};
    s.start_idx = bank_model[addr_stm_start_idx];
    s.finish_idx = bank_model[addr_stm_finish_idx];
    return s;
  endfunction

  function automatic void check_word(input string what, input logic [15:0] got,
                                     input logic [15:0] exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at time %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endfunction

  task automatic host_idle();
    @(posedge CLK);
    host <= '0;
  endtask

  task automatic host_write(input logic [2:0] page, input logic [7:0] addr,
                            input logic [15:0] data);
    host_bus_t w;
    w.en = 1'b1;
    w.we = 1'b1;
    w.page = page;
    w.addr = addr;
    w.wdata = data;
    @(posedge CLK);
    host <= w;
    if (page == page_main) begin
      bank_model[addr[bank_addr_w-1:0]] = data;
    end else begin
      delay_model[addr[trans_idx_w-1:0]] = data;
    end
  endtask

  // Read data is registered one cycle after the request.
  task automatic host_read(input logic [2:0] page, input logic [7:0] addr,
                           output logic [15:0] data);
    host_bus_t r;
    r = '0;
    r.en = 1'b1;
    r.page = page;
    r.addr = addr;
    @(posedge CLK);
    host <= r;
    @(posedge CLK);
    host <= '0;
    @(negedge CLK);
    data = rdata;
  endtask

  // ==================================================
  // Test steps
  // ==================================================

  task automatic run_settings_round();
    logic [15:0] flag_word;
    mod_cfg_t exp_mod;
    stm_cfg_t exp_stm;
    logic seen;
    flag_word = 16'(rand_bits(16));
    flag_word[flag_sync_bit] = 1'b0;
    host_write(page_main, {1'b0, addr_ctl_flag}, flag_word);
    for (int i = 0; i < 11; i++) begin
      host_write(page_main, {1'b0, setting_addrs[i]}, 16'(rand_bits(16)));
    end
    host_idle();
    exp_mod = expect_mod();
    exp_stm = expect_stm();
    seen = 1'b0;
    for (int n = 0; n < setting_wait && !seen; n++) begin
      @(negedge CLK);
      if (mod_cfg === exp_mod && stm_cfg === exp_stm && flags === flag_word
          && force_fan === flag_word[flag_force_fan_bit]) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      mismatch_cnt++;
      $display("Mismatch at time %0t: mod_cfg %h stm_cfg %h flags %h fan %b", $time,
               mod_cfg, stm_cfg, flags, force_fan);
      $display("  expected mod_cfg %h stm_cfg %h flags %h", exp_mod, exp_stm, flag_word);
    end
  endtask

  task automatic run_thermo_round();
    logic t;
    logic [15:0] got;
    t = 1'(rand_bits(1));
    @(posedge CLK);
    thermo <= t;
    repeat (setting_wait) @(posedge CLK);
    host_read(page_main, {1'b0, addr_fpga_info}, got);
    check_word("fpga_info", got, {15'd0, t});
  endtask

  task automatic run_sync_round();
    logic [15:0] base;
    logic [15:0] got;
    logic [63:0] exp_time;
    int pulses;
    exp_time = {rand_bits(32), rand_bits(32)};
    base = 16'(rand_bits(16));
    base[flag_sync_bit] = 1'b0;
    host_write(page_main, {1'b0, addr_sync_time_0}, exp_time[15:0]);
    host_write(page_main, {1'b0, addr_sync_time_1}, exp_time[31:16]);
    host_write(page_main, {1'b0, addr_sync_time_2}, exp_time[47:32]);
    host_write(page_main, {1'b0, addr_sync_time_3}, exp_time[63:48]);
    host_write(page_main, {1'b0, addr_ctl_flag}, base | (16'd1 << flag_sync_bit));
    host_idle();
    pulses = 0;
    for (int n = 0; n < sync_wait; n++) begin
      @(negedge CLK);
      if (sync_set === 1'b1) begin
        pulses++;
        if (ecat_sync_time !== exp_time) begin
          mismatch_cnt++;
          $display("Mismatch at time %0t: ecat_sync_time %h, expected %h", $time,
                   ecat_sync_time, exp_time);
        end
      end
    end
    if (pulses != 1) begin
      fail_cnt++;
      $display("Expected one sync_set pulse within %0d cycles but saw %0d", sync_wait, pulses);
    end
    // The sequencer clears sync in the bank.
    bank_model[addr_ctl_flag] = base;
    host_read(page_main, {1'b0, addr_ctl_flag}, got);
    check_word("ctl_flag after sync", got, base);
  endtask

  task automatic run_delay_write(input int idx);
    logic [15:0] val;
    logic seen;
    val = 16'(rand_bits(16));
    host_write(page_delay, 8'(idx), val);
    host_idle();
    seen = 1'b0;
    for (int n = 0; n <= delay_wait && !seen; n++) begin
      @(negedge CLK);
      if (delays[idx] === val) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      mismatch_cnt++;
      $display("Mismatch at time %0t: delays[%0d] %h, expected %h", $time, idx,
               delays[idx], val);
    end
  endtask

  task automatic print_counts();
    $display("Run ended: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================

  initial begin
    logic [15:0] got;
    host = '0;
    thermo = 1'b0;
    arst_n = 1'b0;
    lfsr_state = 16'd19;
    mismatch_cnt = 0;
    fail_cnt = 0;
    repeat (9) @(posedge CLK);
    @(negedge CLK);
    if ({flags, mod_cfg, stm_cfg, ecat_sync_time, delays} !== '0 || sync_set !== 1'b0) begin
      mismatch_cnt++;
      $display("Mismatch at time %0t: outputs not cleared in reset", $time);
    end
    @(posedge CLK);
    arst_n <= 1'b1;
    repeat (4) @(posedge CLK);

    host_read(page_main, {1'b0, addr_ver_minor}, got);
    check_word("ver_minor", got, {8'h00, version_minor});
    host_read(page_main, {1'b0, addr_ver_major}, got);
    check_word("ver_major", got, {8'hff, version_major});

    for (int i = 0; i < setting_rounds; i++) begin
      run_settings_round();
    end
    for (int i = 0; i < thermo_rounds; i++) begin
      run_thermo_round();
    end
    for (int i = 0; i < sync_rounds; i++) begin
      run_sync_round();
    end

    // Fill every entry first, then hit random entries.
    for (int i = 0; i < num_trans; i++) begin
      run_delay_write(i);
    end
    for (int i = 0; i < delay_writes; i++) begin
      run_delay_write(int'(rand_bits(trans_idx_w)));
    end
    host_read(page_delay, 8'd0, got);
    check_word("delay page", got, 16'd0);
    for (int i = 0; i < num_trans; i++) begin
      if (delays[i] !== delay_model[i]) begin
        mismatch_cnt++;
        $display("Mismatch at time %0t: final delays[%0d] %h, expected %h", $time, i,
                 delays[i], delay_model[i]);
      end
    end

    print_counts();
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    fail_cnt++;
    $display("Timeout after %0d cycles, the test sequence did not complete", cycle_limit);
    print_counts();
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- list.f
ctl_pkg.sv
ctl_regbank.sv
delay_table.sv
ctl_sequencer.sv
ctl_top.sv
ctl_chk.sv
ctl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ctl_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes.
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
